/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = debug_tb
FILELIST  = mips_debug.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* logic/debug_control.sv */
`timescale 1ns/1ps

module debug_control (
  input  logic                i_clock,
  input  logic                i_reset,
  input  debug_pkg::rx_byte_t i_rx_byte,
  input  logic                i_soft_reset_ack,
  input  logic                i_halt_written,
  input  logic                i_tx_busy,
  output logic                o_tx_start,
  output logic [7:0]          o_tx_data,
  output logic                o_loading,
  output logic                o_soft_reset,
  output logic                o_run,
  output logic                o_step_mode
);

  debug_pkg::debug_state_e state;

  logic cmd_reset;
  logic cmd_load;
  logic cmd_go;

  ////////////////////
  // Command decode

  assign cmd_reset = i_rx_byte.valid && (i_rx_byte.data == debug_pkg::CMD_RESET);
  assign cmd_load  = i_rx_byte.valid && (i_rx_byte.data == debug_pkg::CMD_LOAD);
  assign cmd_go    = i_rx_byte.valid &&
                     ((i_rx_byte.data == debug_pkg::CMD_RUN) ||
                      (i_rx_byte.data == debug_pkg::CMD_STEP));

  ////////////////////
  // FSM

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state        <= debug_pkg::IDLE;
      o_tx_start   <= 1'b0;
      o_tx_data    <= '0;
      o_loading    <= 1'b0;
      o_soft_reset <= 1'b1;  // Active low.
      o_run        <= 1'b0;
      o_step_mode  <= 1'b0;
    end else begin
      o_tx_start <= 1'b0;  // Pulse only.
      case (state)
        debug_pkg::IDLE,
        debug_pkg::RUN: begin
          if (cmd_reset) begin
            state        <= debug_pkg::SOFT_RESET;
            o_soft_reset <= 1'b0;
            o_run        <= 1'b0;  // CPU halts while in reset.
            o_step_mode  <= 1'b0;
          end
        end
        debug_pkg::SOFT_RESET: begin
          if (!i_soft_reset_ack) begin
            state        <= debug_pkg::SEND_ACK;
            o_soft_reset <= 1'b1;
          end
        end
        debug_pkg::SEND_ACK: begin
          if (!i_tx_busy) begin
            o_tx_start <= 1'b1;
            o_tx_data  <= debug_pkg::ACK_BYTE;
            state      <= debug_pkg::WAIT_LOAD;
          end
        end
        debug_pkg::WAIT_LOAD: begin
          if (cmd_load) begin
            state     <= debug_pkg::LOAD;
            o_loading <= 1'b1;
          end
        end
        debug_pkg::LOAD: begin
          // Every byte here is program data.
          if (i_halt_written) begin
            state     <= debug_pkg::WAIT_START;
            o_loading <= 1'b0;
          end
        end
        debug_pkg::WAIT_START: begin
          if (cmd_go) begin
            state       <= debug_pkg::RUN;
            o_run       <= 1'b1;
            o_step_mode <= i_rx_byte.data[2];  // Step when set.
          end
        end
        default: state <= debug_pkg::IDLE;
      endcase
    end
  end

  a_run_not_in_reset: assert property (@(posedge i_clock) disable iff (!i_reset)
    !(o_run && !o_soft_reset));

endmodule

/* logic/debug_pkg.sv */
package debug_pkg;

  ////////////////////
  // Word format

  localparam int INSTR_WIDTH = 32;    // MIPS instruction width.
  localparam int BYTES_PER_WORD = 4;  // Serial bytes per instruction.

  ////////////////////
  // Encodings

  typedef enum logic [2:0] {
    IDLE,
    SOFT_RESET,
    SEND_ACK,
    WAIT_LOAD,
    LOAD,
    WAIT_START,
    RUN
  } debug_state_e;

  typedef enum logic [7:0] {
    CMD_RESET = 8'h00,
    CMD_LOAD  = 8'h01,
    CMD_RUN   = 8'h03,
    CMD_STEP  = 8'h07  // Bit 2 selects single step.
  } host_cmd_e;

  localparam logic [7:0] ACK_BYTE = 8'h01;  // Reply after soft reset ack.

  ////////////////////
  // Bundles

  typedef struct packed {
    logic       valid;  // One cycle per frame.
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic                   en;
    logic [15:0]            addr;  // Memory uses the low bits.
    logic [INSTR_WIDTH-1:0] data;
  } mem_write_t;

endpackage

/* logic/debug_top.sv */
`timescale 1ns/1ps

module debug_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int ADDR_WIDTH   = 10
) (
  input  logic                              i_clock,
  input  logic                              i_reset,
  input  logic                              i_rx_serial,
  input  logic                              i_soft_reset_ack,
  input  logic [ADDR_WIDTH-1:0]             i_fetch_addr,
  output logic                              o_tx_serial,
  output logic                              o_soft_reset,
  output logic                              o_run,
  output logic                              o_step_mode,
  output logic [debug_pkg::INSTR_WIDTH-1:0] o_fetch_instr
);

  debug_pkg::rx_byte_t   rx_byte;
  debug_pkg::mem_write_t mem_wr;
  logic                  halt_written;
  logic                  loading;
  logic                  tx_start;
  logic [7:0]            tx_data;
  logic                  tx_busy;

  ////////////////////
  // Host serial link

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_rx_serial (i_rx_serial),
    .o_rx_byte   (rx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_tx_start  (tx_start),
    .i_tx_data   (tx_data),
    .o_tx_serial (o_tx_serial),
    .o_tx_busy   (tx_busy)
  );

  ////////////////////
  // Loader and control

  word_assembler #(.ADDR_WIDTH(ADDR_WIDTH)) u_word_assembler (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_loading      (loading),
    .i_rx_byte      (rx_byte),
    .o_mem_wr       (mem_wr),
    .o_halt_written (halt_written)
  );

  program_memory #(.ADDR_WIDTH(ADDR_WIDTH)) u_program_memory (
    .i_clock       (i_clock),
    .i_mem_wr      (mem_wr),
    .i_fetch_addr  (i_fetch_addr),
    .o_fetch_instr (o_fetch_instr)
  );

  debug_control u_debug_control (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_byte        (rx_byte),
    .i_soft_reset_ack (i_soft_reset_ack),
    .i_halt_written   (halt_written),
    .i_tx_busy        (tx_busy),
    .o_tx_start       (tx_start),
    .o_tx_data        (tx_data),
    .o_loading        (loading),
    .o_soft_reset     (o_soft_reset),
    .o_run            (o_run),
    .o_step_mode      (o_step_mode)
  );

endmodule

/* logic/program_memory.sv */
`timescale 1ns/1ps

module program_memory #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                              i_clock,
  input  debug_pkg::mem_write_t             i_mem_wr,
  input  logic [ADDR_WIDTH-1:0]             i_fetch_addr,
  output logic [debug_pkg::INSTR_WIDTH-1:0] o_fetch_instr
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [debug_pkg::INSTR_WIDTH-1:0] mem [DEPTH];

  ////////////////////
  // Loader port

  always_ff @(posedge i_clock) begin
    if (i_mem_wr.en) begin
      mem[i_mem_wr.addr[ADDR_WIDTH-1:0]] <= i_mem_wr.data;
    end
  end

  ////////////////////
  // Fetch port

  always_ff @(posedge i_clock) begin
    o_fetch_instr <= mem[i_fetch_addr];  // One cycle latency.
  end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 16  // 8 or more.
) (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_rx_serial,
  output debug_pkg::rx_byte_t o_rx_byte
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  localparam int CNT_WIDTH = $clog2(CLKS_PER_BIT);
  localparam int SYNC_LAT = 3;  // Synchronizer plus edge detect.
  localparam int START_WAIT = CLKS_PER_BIT / 2 - SYNC_LAT;

  logic                 rx_meta;
  logic                 rx_sync;
  rx_state_e            state;
  logic [CNT_WIDTH-1:0] baud_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shift;
  logic                 rx_valid;
  logic                 bit_end;

  assign bit_end = (baud_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx_serial;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rx_sync) state <= RX_START;  // Falling edge seen.
        end
        RX_START: begin
          if (baud_cnt == CNT_WIDTH'(START_WAIT)) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch rejected.
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            rx_valid <= rx_sync;  // Low stop bit drops the frame.
            state    <= RX_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clock) begin
    if (state == RX_DATA && bit_end) shift <= {rx_sync, shift[7:1]};  // LSB first.
  end

  assign o_rx_byte = '{valid: rx_valid, data: shift};

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       i_clock,
  input  logic       i_reset,
  input  logic       i_tx_start,
  input  logic [7:0] i_tx_data,
  output logic       o_tx_serial,
  output logic       o_tx_busy
);

  localparam int CNT_WIDTH = $clog2(CLKS_PER_BIT);

  logic [CNT_WIDTH-1:0] baud_cnt;
  logic [3:0]           bit_cnt;
  logic [8:0]           frame;  // Data bits then stop bit.

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      o_tx_serial <= 1'b1;  // Idle line.
      o_tx_busy   <= 1'b0;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
    end else if (!o_tx_busy) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
      if (i_tx_start) begin
        o_tx_serial <= 1'b0;  // Start bit.
        o_tx_busy   <= 1'b1;
      end
    end else if (baud_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        o_tx_busy <= 1'b0;  // Stop bit done.
      end else begin
        o_tx_serial <= frame[0];
        bit_cnt     <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!o_tx_busy && i_tx_start) begin
      frame <= {1'b1, i_tx_data};
    end else if (o_tx_busy && baud_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
      frame <= {1'b1, frame[8:1]};  // LSB first.
    end
  end

  // A start during a frame would be lost.
  a_no_start_busy: assert property (@(posedge i_clock) disable iff (!i_reset)
    !(i_tx_start && o_tx_busy));

endmodule

/* logic/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_loading,
  input  debug_pkg::rx_byte_t   i_rx_byte,
  output debug_pkg::mem_write_t o_mem_wr,
  output logic                  o_halt_written
);

  localparam int W = debug_pkg::INSTR_WIDTH;
  localparam int CNT_WIDTH = $clog2(debug_pkg::BYTES_PER_WORD);

  logic [W-1:0]          shift;
  logic [W-1:0]          next_word;
  logic [W-1:0]          wr_data;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] addr_cnt;
  logic [CNT_WIDTH-1:0]  byte_cnt;
  logic                  wr_en;
  logic                  take;
  logic                  word_done;

  assign take      = i_loading && i_rx_byte.valid;
  assign next_word = {shift[W-9:0], i_rx_byte.data};  // MSB first.
  assign word_done = take && (byte_cnt == CNT_WIDTH'(debug_pkg::BYTES_PER_WORD - 1));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_cnt       <= '0;
      addr_cnt       <= '0;
      wr_en          <= 1'b0;
      o_halt_written <= 1'b0;
    end else begin
      wr_en          <= word_done;
      o_halt_written <= word_done && (next_word == '0);  // HALT word.
      if (!i_loading) begin
        byte_cnt <= '0;  // Restart at address 0.
        addr_cnt <= '0;
      end else if (take) begin
        byte_cnt <= word_done ? '0 : byte_cnt + 1'b1;
        if (word_done) addr_cnt <= addr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (take) shift <= next_word;
    if (word_done) begin
      wr_data <= next_word;
      wr_addr <= addr_cnt;
    end
  end

  assign o_mem_wr = '{en: wr_en, addr: 16'(wr_addr), data: wr_data};

  a_write_while_loading: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_mem_wr.en |-> i_loading);

endmodule

/* mips_debug.f */
logic/debug_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/word_assembler.sv
logic/program_memory.sv
logic/debug_control.sv
logic/debug_top.sv
verif/debug_tb.sv

/* verif/debug_golden.txt */
# B count value: send count bytes MSB first. T value: expect a byte on the tx line.
# M addr word: expect a fetched word. S run step: expect o_run and o_step_mode.
S 0 0
B 1 03
B 1 01
B 1 07
S 0 0
B 1 00
T 01
B 1 01
B 4 20080005
B 4 2009000a
B 4 01095020
B 4 ac0a0000
B 4 00000000
M 000 20080005
M 001 2009000a
M 002 01095020
M 003 ac0a0000
M 004 00000000
B 1 07
S 1 1
B 1 00
S 0 0
T 01
B 1 01
B 4 3c01abcd
B 4 34211234
B 4 00000000
M 000 3c01abcd
M 001 34211234
M 002 00000000
M 003 ac0a0000
B 1 03
S 1 0
B 1 00
S 0 0
T 01

/* verif/debug_tb.sv */
`timescale 1ns/1ps

module debug_tb;

  localparam int CLKS_PER_BIT = 8;
  localparam int ADDR_WIDTH   = 10;
  localparam int TIMEOUT      = 4000;  // Cycles per wait.
  localparam int W            = debug_pkg::INSTR_WIDTH;

  logic                  i_clock;
  logic                  i_reset;
  logic                  i_rx_serial;
  logic                  i_soft_reset_ack;
  logic [ADDR_WIDTH-1:0] i_fetch_addr;
  logic                  o_tx_serial;
  logic                  o_soft_reset;
  logic                  o_run;
  logic                  o_step_mode;
  logic [W-1:0]          o_fetch_instr;

  logic [7:0]  tx_queue[$];  // Bytes decoded from o_tx_serial.
  logic [31:0] rng_state;
  logic        reset_done;

  debug_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .ADDR_WIDTH(ADDR_WIDTH)) uut (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_serial      (i_rx_serial),
    .i_soft_reset_ack (i_soft_reset_ack),
    .i_fetch_addr     (i_fetch_addr),
    .o_tx_serial      (o_tx_serial),
    .o_soft_reset     (o_soft_reset),
    .o_run            (o_run),
    .o_step_mode      (o_step_mode),
    .o_fetch_instr    (o_fetch_instr)
  );

  initial begin
    i_clock = 1'b0;
    forever #20 i_clock = ~i_clock;  // 40 ns period.
  end

  ////////////////////
  // Helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  // 8N1 frame, then an idle gap of 0 to 15 bit times.
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    int         gap;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge i_clock);
      i_rx_serial = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge i_clock);
    end
    rng_state = xorshift(rng_state);
    gap = int'(rng_state % 16);
    repeat (gap * CLKS_PER_BIT) @(negedge i_clock);
  endtask

  task automatic send_bytes(input logic [31:0] count, input logic [31:0] value);
    for (int k = int'(count) - 1; k >= 0; k--) begin
      send_byte(value[8*k +: 8]);  // MSB first.
    end
  endtask

  task automatic expect_tx(input string name, input logic [7:0] exp);
    int waited;
    waited = 0;
    while (tx_queue.size() == 0 && waited < TIMEOUT) begin
      @(negedge i_clock);
      waited++;
    end
    if (tx_queue.size() == 0) begin
      report_failure($sformatf("timed out waiting for a byte on o_tx_serial at %s", name));
    end else begin
      check_byte(name, exp, tx_queue.pop_front());
    end
  endtask

  task automatic read_word(input string name, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [W-1:0] exp);
    @(negedge i_clock);
    i_fetch_addr = addr;
    @(negedge i_clock);  // Registered read.
    check_word(name, exp, o_fetch_instr);
  endtask

  ////////////////////
  // CPU and host models

  initial begin : cpu_model
    int delay;
    i_soft_reset_ack = 1'b1;
    delay = 0;
    forever begin
      @(negedge i_clock);
      if (o_soft_reset === 1'b0) begin
        if (delay == 3) begin
          i_soft_reset_ack = 1'b0;  // Acknowledge a few cycles later.
        end else begin
          delay++;
        end
      end else begin
        delay = 0;
        i_soft_reset_ack = 1'b1;
      end
    end
  end

  initial begin : tx_monitor
    logic [7:0] data;
    forever begin
      @(negedge i_clock);
      if (reset_done && o_tx_serial === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge i_clock);  // Middle of start bit.
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge i_clock);
          data[i] = o_tx_serial;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clock);
        if (o_tx_serial !== 1'b1) begin
          report_failure("stop bit on o_tx_serial was not high");
        end else begin
          tx_queue.push_back(data);
        end
      end
    end
  end

  ////////////////////
  // Golden script

  initial begin : script
    int               fd;
    int               code;
    int               line_no;
    logic [7:0]       op;
    logic [31:0]      arg_a;
    logic [31:0]      arg_b;
    logic [8*120-1:0] skip_line;
    string            name;
    i_reset      = 1'b0;
    i_rx_serial  = 1'b1;
    i_fetch_addr = '0;
    rng_state    = 32'd40;
    reset_done   = 1'b0;
    line_no      = 0;
    repeat (10) @(negedge i_clock);
    i_reset    = 1'b1;
    reset_done = 1'b1;
    @(negedge i_clock);
    check_state("o_soft_reset after reset", 1'b1, o_soft_reset);
    check_state("o_tx_serial after reset", 1'b1, o_tx_serial);
    fd = $fopen("verif/debug_golden.txt", "r");
    if (fd == 0) report_failure("could not open verif/debug_golden.txt");
    while ($fscanf(fd, " %c", op) == 1) begin
      line_no++;
      name = $sformatf("golden line %0d", line_no);
      case (op)
        "#": code = $fgets(skip_line, fd);
        "B": begin
          code = $fscanf(fd, "%h %h", arg_a, arg_b);
          if (code != 2) report_failure($sformatf("bad B record at %s", name));
          send_bytes(arg_a, arg_b);
        end
        "T": begin
          code = $fscanf(fd, "%h", arg_a);
          if (code != 1) report_failure($sformatf("bad T record at %s", name));
          expect_tx(name, arg_a[7:0]);
          check_state({name, " o_soft_reset"}, 1'b1, o_soft_reset);  // Released after ack.
        end
        "M": begin
          code = $fscanf(fd, "%h %h", arg_a, arg_b);
          if (code != 2) report_failure($sformatf("bad M record at %s", name));
          read_word(name, arg_a[ADDR_WIDTH-1:0], arg_b);
        end
        "S": begin
          code = $fscanf(fd, "%h %h", arg_a, arg_b);
          if (code != 2) report_failure($sformatf("bad S record at %s", name));
          repeat (CLKS_PER_BIT) @(negedge i_clock);  // One bit time to settle.
          check_state({name, " o_run"}, arg_a[0], o_run);
          check_state({name, " o_step_mode"}, arg_b[0], o_step_mode);
        end
        default: report_failure($sformatf("unknown record type at %s", name));
      endcase
    end
    $fclose(fd);
    repeat (12 * CLKS_PER_BIT) @(negedge i_clock);  // Let a stray frame finish.
    if (tx_queue.size() != 0) begin
      report_failure("unexpected extra byte on o_tx_serial");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule
